/* src.f */
+incdir+.
fpslice_pkg.sv
fpslice_lane_op.sv
fpslice_pipe.sv
fpslice_pack.sv
fpslice_top.sv
tb_fpslice.sv

/* run_sim.sh */
#!/bin/sh
# Build the FP slice testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_fpslice -f src.f -o tb_fpslice_sim \
  || { echo "Build failed"; exit 1; }

sim_out=$(./obj_dir/tb_fpslice_sim 2>&1)
printf '%s\n' "$sim_out"

printf '%s\n' "$sim_out" | grep -qF '** PASS **' && exit 0 || exit 1

/* tb_fpslice_vectors.svh */
// Stimulus and expected results for the FP slice testbench, included inside the testbench module
`ifndef TB_FPSLICE_VECTORS_SVH
`define TB_FPSLICE_VECTORS_SVH

localparam int NUM_VECTORS = 23;

vector_t vectors [NUM_VECTORS];

// Fields: op, format, vector flag, operand A, operand B, mask, expected result, expected status
task automatic load_vectors();
  // Scalar FP32 sign injection, upper word boxed with ones
  vectors[0]  = '{SGNJ,  FP32, 1'b0, 64'h1234_5678_3F80_0000, 64'h0000_0000_C000_0000,
                  4'b0001, 64'hFFFF_FFFF_BF80_0000, 5'h00};
  vectors[1]  = '{SGNJN, FP32, 1'b0, 64'h0000_0000_BF80_0000, 64'hFFFF_FFFF_C000_0000,
                  4'b0001, 64'hFFFF_FFFF_3F80_0000, 5'h00};
  vectors[2]  = '{SGNJX, FP32, 1'b0, 64'h0000_0000_C120_0000, 64'h0000_0000_8000_0000,
                  4'b0001, 64'hFFFF_FFFF_4120_0000, 5'h00};
  vectors[3]  = '{SGNJ,  FP32, 1'b0, 64'h0000_0000_7F80_0001, 64'h0000_0000_8000_0000,
                  4'b0001, 64'hFFFF_FFFF_FF80_0001, 5'h00};  // No flag on sNaN
  // Scalar FP32 min/max
  vectors[4]  = '{FMIN,  FP32, 1'b0, 64'h0000_0000_3F80_0000, 64'h0000_0000_C000_0000,
                  4'b0001, 64'hFFFF_FFFF_C000_0000, 5'h00};
  vectors[5]  = '{FMAX,  FP32, 1'b0, 64'h0000_0000_3F80_0000, 64'h0000_0000_C000_0000,
                  4'b0001, 64'hFFFF_FFFF_3F80_0000, 5'h00};
  vectors[6]  = '{FMIN,  FP32, 1'b0, 64'h0000_0000_0000_0000, 64'h0000_0000_8000_0000,
                  4'b0001, 64'hFFFF_FFFF_8000_0000, 5'h00};
  vectors[7]  = '{FMAX,  FP32, 1'b0, 64'h0000_0000_8000_0000, 64'h0000_0000_0000_0000,
                  4'b0001, 64'hFFFF_FFFF_0000_0000, 5'h00};
  vectors[8]  = '{FMIN,  FP32, 1'b0, 64'h0000_0000_7FC0_0000, 64'h0000_0000_4040_0000,
                  4'b0001, 64'hFFFF_FFFF_4040_0000, 5'h00};
  vectors[9]  = '{FMAX,  FP32, 1'b0, 64'h0000_0000_7F80_0001, 64'h0000_0000_7FC0_0000,
                  4'b0001, 64'hFFFF_FFFF_7FC0_0000, 5'h10};  // Both NaN
  vectors[10] = '{FMIN,  FP32, 1'b0, 64'h0000_0000_C040_0000, 64'h0000_0000_C000_0000,
                  4'b0001, 64'hFFFF_FFFF_C040_0000, 5'h00};
  // Vector FP32, two lanes
  vectors[11] = '{FMAX,  FP32, 1'b1, 64'h4000_0000_7F80_0001, 64'h4040_0000_3F80_0000,
                  4'b0011, 64'h4040_0000_3F80_0000, 5'h10};
  vectors[12] = '{FMIN,  FP32, 1'b1, 64'h7FA0_0000_BF80_0000, 64'hC000_0000_3F80_0000,
                  4'b0001, 64'hC000_0000_BF80_0000, 5'h00};  // sNaN lane masked off
  // Vector FP16, four lanes
  vectors[13] = '{FMIN,  FP16, 1'b1, 64'h3C00_7C01_7E00_0000, 64'h4000_7E00_C000_8000,
                  4'b1111, 64'h3C00_7E00_C000_8000, 5'h10};
  vectors[14] = '{FMAX,  FP16, 1'b1, 64'h3C00_7C01_7E00_0000, 64'h4000_7E00_C000_8000,
                  4'b1111, 64'h4000_7E00_C000_0000, 5'h10};
  vectors[15] = '{FMAX,  FP16, 1'b1, 64'hFC00_7C00_3800_BC00, 64'h8000_4000_3C00_C000,
                  4'b1111, 64'h8000_7C00_3C00_BC00, 5'h00};
  vectors[16] = '{FMIN,  FP16, 1'b1, 64'h7D00_C000_8000_3C00, 64'h3C00_BC00_0000_3800,
                  4'b0111, 64'h3C00_C000_8000_3800, 5'h00};  // sNaN in lane 3
  vectors[17] = '{SGNJX, FP16, 1'b1, 64'hBC00_7E00_C000_3C00, 64'h0000_3C00_C000_8000,
                  4'b1111, 64'hBC00_7E00_4000_BC00, 5'h00};
  // Scalar FP16
  vectors[18] = '{SGNJN, FP16, 1'b0, 64'h1234_5678_9ABC_4000, 64'h0F0F_0F0F_0F0F_3C00,
                  4'b0001, 64'hFFFF_FFFF_FFFF_C000, 5'h00};
  vectors[19] = '{FMAX,  FP16, 1'b0, 64'h0000_0000_0000_0001, 64'h0000_0000_0000_7C01,
                  4'b0001, 64'hFFFF_FFFF_FFFF_0001, 5'h10};
  vectors[20] = '{FMIN,  FP16, 1'b0, 64'h0000_0000_0000_7C01, 64'h0000_0000_0000_3C00,
                  4'b0000, 64'hFFFF_FFFF_FFFF_3C00, 5'h00};
  // Scalar ops leave the upper lanes idle, so their sNaNs raise no flag
  vectors[21] = '{FMAX,  FP32, 1'b0, 64'h7F80_0001_3F80_0000, 64'h7F80_0001_4000_0000,
                  4'b0011, 64'hFFFF_FFFF_4000_0000, 5'h00};
  vectors[22] = '{FMIN,  FP16, 1'b0, 64'h7C01_7C01_7C01_3C00, 64'h7C01_7C01_7C01_4000,
                  4'b1111, 64'hFFFF_FFFF_FFFF_3C00, 5'h00};
endtask

`endif

/* tb_fpslice.sv */
// Testbench for the FP slice top level; runs the vector table with random back-pressure and a flush
`timescale 1ns/10ps

module tb_fpslice;

  import fpslice_pkg::*;

  localparam int unsigned NUM_PIPE_REGS = 2;

  // One table entry with its expected response
  typedef struct packed {
    operation_e  op;
    fp_format_e  fmt;
    logic        vec;
    logic [63:0] a;
    logic [63:0] b;
    logic [3:0]  mask;
    logic [63:0] exp_result;
    logic [4:0]  exp_status;  // {NV, DZ, OF, UF, NX}
  } vector_t;

  `include "tb_fpslice_vectors.svh"

  localparam int TIMEOUT_CYCLES = 20 * NUM_VECTORS + 200;

  logic                                    clk_i;
  logic                                    reset_i;
  logic [NUM_OPERANDS-1:0][SLICE_WIDTH-1:0] operands_i;
  operation_e                              op_i;
  fp_format_e                              fmt_i;
  logic                                    vectorial_op_i;
  logic [7:0]                              tag_i;
  logic [NUM_LANES-1:0]                    simd_mask_i;
  logic                                    in_valid_i;
  logic                                    in_ready_o;
  logic                                    flush_i;
  logic [SLICE_WIDTH-1:0]                  result_o;
  status_t                                 status_o;
  logic [7:0]                              tag_o;
  logic                                    out_valid_o;
  logic                                    out_ready_i;
  logic                                    busy_o;

  integer      seed = 32'h661869b2;
  logic [31:0] rand_word;
  logic        random_ready = 1'b0;  // Randomize out_ready_i when set
  int          cycle_count = 0;
  int          recv_count = 0;
  int          accepted = 0;
  vector_t     expected;
  logic        hold_pending = 1'b0;  // Output was stalled at the last edge
  logic [63:0] held_result;
  logic [4:0]  held_status;
  logic [7:0]  held_tag;

  fpslice_top #(
    .NumPipeRegs ( NUM_PIPE_REGS ),
    .TagType     ( logic [7:0]   )
  ) dut_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .operands_i     ( operands_i     ),
    .op_i           ( op_i           ),
    .fmt_i          ( fmt_i          ),
    .vectorial_op_i ( vectorial_op_i ),
    .tag_i          ( tag_i          ),
    .simd_mask_i    ( simd_mask_i    ),
    .in_valid_i     ( in_valid_i     ),
    .in_ready_o     ( in_ready_o     ),
    .flush_i        ( flush_i        ),
    .result_o       ( result_o       ),
    .status_o       ( status_o       ),
    .tag_o          ( tag_o          ),
    .out_valid_o    ( out_valid_o    ),
    .out_ready_i    ( out_ready_i    ),
    .busy_o         ( busy_o         )
  );

  always #4 clk_i = ~clk_i;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp_val);
    if (got !== exp_val) begin
      $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp_val);
      $display("** FAIL **");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic apply_entry(input vector_t entry, input logic [7:0] tag);
    operands_i[0]  = entry.a;
    operands_i[1]  = entry.b;
    op_i           = entry.op;
    fmt_i          = entry.fmt;
    vectorial_op_i = entry.vec;
    simd_mask_i    = entry.mask;
    tag_i          = tag;
  endtask

  // ----------------------------------------------------------
  // Output monitor, timeout and back-pressure
  // ----------------------------------------------------------
  always @(posedge clk_i) begin : monitor
    if (hold_pending) begin  // Stalled output must not move
      check_value("out_valid_o while stalled", 64'(out_valid_o), 64'd1);
      check_value("result_o while stalled", result_o, held_result);
      check_value("status_o while stalled", 64'(status_o), 64'(held_status));
      check_value("tag_o while stalled", 64'(tag_o), 64'(held_tag));
    end
    hold_pending = out_valid_o & ~out_ready_i & ~flush_i & ~reset_i;
    held_result  = result_o;
    held_status  = status_o;
    held_tag     = tag_o;
    if (!reset_i && out_valid_o && out_ready_i) begin
      if (recv_count >= NUM_VECTORS) begin
        $display("ERROR: output transfer with tag 0x%h after the last table entry", tag_o);
        $display("** FAIL **");
        $fatal(1, "Unexpected output");
      end else begin
        expected = vectors[recv_count];
        check_value("tag_o", 64'(tag_o), 64'(recv_count[7:0]));
        check_value("result_o", result_o, expected.exp_result);
        check_value("status_o", 64'(status_o), 64'(expected.exp_status));
        recv_count = recv_count + 1;
      end
    end
  end

  always @(posedge clk_i) begin : timeout
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("ERROR: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $fatal(1, "Timeout");
    end
  end

  always @(posedge clk_i) begin : ready_gen
    if (random_ready) begin
      #1;
      rand_word   = $random(seed);
      out_ready_i = rand_word[0];
    end
  end

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------
  initial begin : stimulus
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    operands_i     = '0;
    op_i           = SGNJ;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b0;
    load_vectors();
    repeat (16) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    check_value("out_valid_o after reset", 64'(out_valid_o), 64'd0);
    check_value("busy_o after reset", 64'(busy_o), 64'd0);
    check_value("in_ready_o after reset", 64'(in_ready_o), 64'd1);

    // Fill the pipe with out_ready_i low, then flush the stalled items
    apply_entry(vectors[0], 8'hEE);
    in_valid_i = 1'b1;
    repeat (NUM_PIPE_REGS + 2) begin
      @(posedge clk_i);
      if (in_ready_o) accepted++;
      #1;
    end
    in_valid_i = 1'b0;
    check_value("items accepted while stalled", 64'(accepted), 64'(NUM_PIPE_REGS));
    check_value("in_ready_o while full", 64'(in_ready_o), 64'd0);
    flush_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_i = 1'b0;
    check_value("busy_o after flush", 64'(busy_o), 64'd0);
    check_value("out_valid_o after flush", 64'(out_valid_o), 64'd0);

    // Table run with random back-pressure, tag is the entry index
    random_ready = 1'b1;
    for (int i = 0; i < NUM_VECTORS; i++) begin
      apply_entry(vectors[i], 8'(i));
      in_valid_i = 1'b1;
      @(posedge clk_i);
      while (!in_ready_o) @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
    wait (recv_count == NUM_VECTORS);
    @(posedge clk_i);
    #1;
    check_value("busy_o when drained", 64'(busy_o), 64'd0);
    check_value("out_valid_o when drained", 64'(out_valid_o), 64'd0);
    $display("** PASS **");
    $finish;
  end

endmodule

/* fpslice_top.sv */
// SIMD non-computational FP slice; top level to instantiate with pipeline depth and tag type
`timescale 1ns/10ps

module fpslice_top #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         TagType     = logic [7:0]
) (
  input  logic                                                              clk_i,
  input  logic                                                              reset_i,
  // Input side
  input  logic [fpslice_pkg::NUM_OPERANDS-1:0][fpslice_pkg::SLICE_WIDTH-1:0] operands_i,
  input  fpslice_pkg::operation_e                                           op_i,
  input  fpslice_pkg::fp_format_e                                           fmt_i,
  input  logic                                                              vectorial_op_i,
  input  TagType                                                            tag_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                                 simd_mask_i,
  input  logic                                                              in_valid_i,
  output logic                                                              in_ready_o,
  input  logic                                                              flush_i,
  // Output side
  output logic [fpslice_pkg::SLICE_WIDTH-1:0]                               result_o,
  output fpslice_pkg::status_t                                              status_o,
  output TagType                                                            tag_o,
  output logic                                                              out_valid_o,
  input  logic                                                              out_ready_i,
  output logic                                                              busy_o
);

  import fpslice_pkg::*;

  localparam int unsigned NUM_FP32_LANES = SLICE_WIDTH / FP32_WIDTH;

  // Item data that bypasses the lanes
  typedef struct packed {
    TagType               tag;
    fp_format_e           fmt;
    logic                 vectorial;
    logic [NUM_LANES-1:0] mask;
  } slice_meta_t;

  logic [NUM_LANES-1:0][FP32_WIDTH-1:0] op_result;
  status_t [NUM_LANES-1:0]              op_status;
  logic [NUM_LANES-1:0][FP16_WIDTH-1:0] lane_result;
  status_t [NUM_LANES-1:0]              lane_status;
  logic [NUM_LANES-1:0]                 lane_valid;
  logic [NUM_LANES-1:0]                 lane_busy;
  slice_meta_t                          meta_in, meta_out;
  logic                                 meta_busy;

  // ----------------------------------------------------------
  // Lanes
  // ----------------------------------------------------------
  for (genvar i = 0; i < NUM_LANES; i++) begin : gen_lanes
    logic [FP32_WIDTH-1:0] op_a, op_b;
    logic                  lane_fed;
    int unsigned           act_idx;  // Lane number within the active format
    lane_word_t            lane_in, lane_out;

    assign op_a = FP32_WIDTH'(operands_i[0] >> (i * fp_width(fmt_i)));
    assign op_b = FP32_WIDTH'(operands_i[1] >> (i * fp_width(fmt_i)));

    fpslice_lane_op #(
      .HasFp32 ( i < NUM_FP32_LANES )
    ) i_lane_op (
      .op_a_i   ( op_a         ),
      .op_b_i   ( op_b         ),
      .op_i     ( op_i         ),
      .fmt_i    ( fmt_i        ),
      .result_o ( op_result[i] ),
      .status_o ( op_status[i] )
    );

    // In FP32 the upper lanes carry the high halves of the FP32 lanes
    assign act_idx  = (fmt_i == FP32) ? (i % NUM_FP32_LANES) : i;
    assign lane_fed = (act_idx == 0) | (vectorial_op_i & (act_idx < lanes_of(fmt_i)));

    always_comb begin : build_word
      lane_in = '{result: '1, status: '0};  // Idle lanes carry a NaN box
      if (lane_fed) begin
        if ((fmt_i == FP32) && (i >= NUM_FP32_LANES)) begin
          lane_in.result = op_result[i % NUM_FP32_LANES][FP32_WIDTH-1 -: FP16_WIDTH];
        end else begin
          lane_in.result = op_result[i][FP16_WIDTH-1:0];
          lane_in.status = op_status[i];
        end
      end
    end

    // Every lane takes every item, so all pipes step together
    fpslice_pipe #(
      .NumPipeRegs ( NumPipeRegs ),
      .PayloadType ( lane_word_t )
    ) i_lane_pipe (
      .clk_i       ( clk_i         ),
      .reset_i     ( reset_i       ),
      .flush_i     ( flush_i       ),
      .in_valid_i  ( in_valid_i    ),
      .in_data_i   ( lane_in       ),
      .in_ready_o  (               ),
      .out_valid_o ( lane_valid[i] ),
      .out_data_o  ( lane_out      ),
      .out_ready_i ( out_ready_i   ),
      .busy_o      ( lane_busy[i]  )
    );

    assign lane_result[i] = lane_out.result;
    assign lane_status[i] = lane_out.status;
  end

  // ----------------------------------------------------------
  // Side pipeline, owns the handshake
  // ----------------------------------------------------------
  assign meta_in = '{tag: tag_i, fmt: fmt_i, vectorial: vectorial_op_i, mask: simd_mask_i};

  fpslice_pipe #(
    .NumPipeRegs ( NumPipeRegs  ),
    .PayloadType ( slice_meta_t )
  ) i_meta_pipe (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .flush_i     ( flush_i     ),
    .in_valid_i  ( in_valid_i  ),
    .in_data_i   ( meta_in     ),
    .in_ready_o  ( in_ready_o  ),
    .out_valid_o ( out_valid_o ),
    .out_data_o  ( meta_out    ),
    .out_ready_i ( out_ready_i ),
    .busy_o      ( meta_busy   )
  );

  // ----------------------------------------------------------
  // Output side
  // ----------------------------------------------------------
  fpslice_pack i_pack (
    .lane_result_i ( lane_result        ),
    .lane_status_i ( lane_status        ),
    .lane_valid_i  ( lane_valid         ),
    .fmt_i         ( meta_out.fmt       ),
    .vectorial_i   ( meta_out.vectorial ),
    .mask_i        ( meta_out.mask      ),
    .result_o      ( result_o           ),
    .status_o      ( status_o           )
  );

  assign tag_o  = meta_out.tag;
  assign busy_o = meta_busy | (|lane_busy);

endmodule

/* fpslice_pack.sv */
// Repacks lane chunks into the result word by format and merges the masked lane flags
`timescale 1ns/10ps

module fpslice_pack (
  input  logic [fpslice_pkg::NUM_LANES-1:0][fpslice_pkg::FP16_WIDTH-1:0] lane_result_i,
  input  fpslice_pkg::status_t [fpslice_pkg::NUM_LANES-1:0]              lane_status_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                              lane_valid_i,
  input  fpslice_pkg::fp_format_e                                        fmt_i,
  input  logic                                                           vectorial_i,
  input  logic [fpslice_pkg::NUM_LANES-1:0]                              mask_i,
  output logic [fpslice_pkg::SLICE_WIDTH-1:0]                            result_o,
  output fpslice_pkg::status_t                                           status_o
);

  import fpslice_pkg::*;

  localparam int unsigned NUM_FP32_LANES = SLICE_WIDTH / FP32_WIDTH;

  logic [NUM_LANES-1:0] lane_used;

  // ----------------------------------------------------------
  // Lane activity
  // ----------------------------------------------------------
  // Upper lanes only count for vector ops inside the format's lane count
  always_comb begin : lane_activity
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_used[i] = lane_valid_i[i] &
                     ((i == 0) | (vectorial_i & (i < int'(lanes_of(fmt_i)))));
    end
  end

  // ----------------------------------------------------------
  // Result and status
  // ----------------------------------------------------------
  always_comb begin : pack_result
    result_o = '1;  // NaN-box everything not written below
    status_o = '0;
    if (fmt_i == FP32) begin
      // Upper half of FP32 lane i sits in chunk lane i + NUM_FP32_LANES
      for (int i = 0; i < NUM_FP32_LANES; i++) begin
        if (lane_used[i] && lane_valid_i[i+NUM_FP32_LANES]) begin
          result_o[i*FP32_WIDTH +: FP32_WIDTH] = {lane_result_i[i+NUM_FP32_LANES],
                                                   lane_result_i[i]};
          if (mask_i[i]) begin
            status_o = status_o | lane_status_i[i];
          end
        end
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (lane_used[i]) begin
          result_o[i*FP16_WIDTH +: FP16_WIDTH] = lane_result_i[i];
          if (mask_i[i]) begin
            status_o = status_o | lane_status_i[i];
          end
        end
      end
    end
  end

endmodule

/* fpslice_pipe.sv */
// Valid/ready register pipeline with flush; carries any payload type through NumPipeRegs stages
`timescale 1ns/10ps

module fpslice_pipe #(
  parameter int unsigned NumPipeRegs = 2,
  parameter type         PayloadType = logic
) (
  input  logic       clk_i,
  input  logic       reset_i,
  input  logic       flush_i,
  input  logic       in_valid_i,
  input  PayloadType in_data_i,
  output logic       in_ready_o,
  output logic       out_valid_o,
  output PayloadType out_data_o,
  input  logic       out_ready_i,
  output logic       busy_o
);

  // Index i holds the item after i register stages
  PayloadType           data_q [0:NumPipeRegs];
  logic [0:NumPipeRegs] valid_q;
  logic [0:NumPipeRegs] ready;

  assign data_q[0]  = in_data_i;
  assign valid_q[0] = in_valid_i;

  // ----------------------------------------------------------
  // Register stages
  // ----------------------------------------------------------
  for (genvar i = 0; i < NumPipeRegs; i++) begin : gen_stage
    logic stage_en;

    // Advance when the next stage moves on or holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    assign stage_en = ready[i] & valid_q[i];

    always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stage_en) begin
        data_q[i+1] <= data_q[i];  // Payload moves with its valid
      end
    end
  end

  assign ready[NumPipeRegs] = out_ready_i;

  // ----------------------------------------------------------
  // Ports
  // ----------------------------------------------------------
  assign in_ready_o  = ready[0];
  assign out_valid_o = valid_q[NumPipeRegs];
  assign out_data_o  = data_q[NumPipeRegs];

  // Anything held in a register stage
  always_comb begin : busy_flag
    busy_o = 1'b0;
    for (int i = 1; i <= NumPipeRegs; i++) begin
      busy_o |= valid_q[i];
    end
  end

endmodule

/* fpslice_lane_op.sv */
// Sign injection and min/max for one lane; purely combinational, instantiated once per lane
`timescale 1ns/10ps

module fpslice_lane_op #(
  parameter bit HasFp32 = 1'b1
) (
  input  logic [fpslice_pkg::FP32_WIDTH-1:0] op_a_i,
  input  logic [fpslice_pkg::FP32_WIDTH-1:0] op_b_i,
  input  fpslice_pkg::operation_e            op_i,
  input  fpslice_pkg::fp_format_e            fmt_i,
  output logic [fpslice_pkg::FP32_WIDTH-1:0] result_o,
  output fpslice_pkg::status_t               status_o
);

  import fpslice_pkg::*;

  localparam int unsigned BOX_BITS = FP32_WIDTH - FP16_WIDTH;

  logic                                    is_fp32;
  logic [NUM_OPERANDS-1:0][FP32_WIDTH-1:0] ops;
  logic [NUM_OPERANDS-1:0][FP32_WIDTH-1:0] boxed;  // Operand as a lane result
  logic [NUM_OPERANDS-1:0][FP32_WIDTH-2:0] mag;
  logic [NUM_OPERANDS-1:0]                 sign, is_zero, is_nan, is_snan;
  logic                                    a_lt_b;
  logic                                    inj_sign;
  logic [FP32_WIDTH-1:0]                   canon_nan;

  assign is_fp32 = HasFp32 && (fmt_i == FP32);  // FP16-only lanes ignore the format
  assign ops     = {op_b_i, op_a_i};

  // ----------------------------------------------------------
  // Operand classification
  // ----------------------------------------------------------
  always_comb begin : classify
    for (int k = 0; k < NUM_OPERANDS; k++) begin
      if (is_fp32) begin
        sign[k]    = ops[k][FP32_WIDTH-1];
        mag[k]     = ops[k][FP32_WIDTH-2:0];
        is_nan[k]  = (&ops[k][FP32_WIDTH-2 -: FP32_EXP_BITS]) & (|ops[k][FP32_MAN_BITS-1:0]);
        is_snan[k] = is_nan[k] & ~ops[k][FP32_MAN_BITS-1];  // Quiet bit clear
        boxed[k]   = ops[k];
      end else begin
        sign[k]    = ops[k][FP16_WIDTH-1];
        mag[k]     = {{BOX_BITS{1'b0}}, ops[k][FP16_WIDTH-2:0]};
        is_nan[k]  = (&ops[k][FP16_WIDTH-2 -: FP16_EXP_BITS]) & (|ops[k][FP16_MAN_BITS-1:0]);
        is_snan[k] = is_nan[k] & ~ops[k][FP16_MAN_BITS-1];
        boxed[k]   = {{BOX_BITS{1'b1}}, ops[k][FP16_WIDTH-1:0]};
      end
      is_zero[k] = (mag[k] == '0);
    end
  end

  assign canon_nan = is_fp32 ? CANON_NAN_FP32 : {{BOX_BITS{1'b1}}, CANON_NAN_FP16};

  // Ordering, -0 sorts below +0
  always_comb begin : compare
    if (is_zero[0] && is_zero[1]) begin
      a_lt_b = sign[0] & ~sign[1];
    end else if (sign[0] != sign[1]) begin
      a_lt_b = sign[0];
    end else begin
      a_lt_b = sign[0] ? (mag[0] > mag[1]) : (mag[0] < mag[1]);  // Negatives flip
    end
  end

  // ----------------------------------------------------------
  // Result select
  // ----------------------------------------------------------
  always_comb begin : select_result
    inj_sign = sign[1];
    result_o = boxed[0];
    status_o = '0;
    unique case (op_i)
      SGNJ, SGNJN, SGNJX: begin
        if (op_i == SGNJN) inj_sign = ~sign[1];
        if (op_i == SGNJX) inj_sign = sign[0] ^ sign[1];
        if (is_fp32) begin
          result_o = {inj_sign, ops[0][FP32_WIDTH-2:0]};
        end else begin
          result_o = {{BOX_BITS{1'b1}}, inj_sign, ops[0][FP16_WIDTH-2:0]};
        end
      end
      FMIN, FMAX: begin
        if (is_nan[0] && is_nan[1]) begin
          result_o = canon_nan;
        end else if (is_nan[0]) begin
          result_o = boxed[1];  // NaN loses against a number
        end else if (is_nan[1]) begin
          result_o = boxed[0];
        end else if ((op_i == FMIN) == a_lt_b) begin
          result_o = boxed[0];
        end else begin
          result_o = boxed[1];
        end
        status_o.NV = |is_snan;
      end
      default: result_o = boxed[0];
    endcase
  end

endmodule

/* fpslice_pkg.sv */
// Common widths, encodings and helpers for the FP slice; modules import it where they need it
package fpslice_pkg;

  // ----------------------------------------------------------
  // Slice geometry
  // ----------------------------------------------------------
  localparam int unsigned SLICE_WIDTH  = 64;  // Operand and result word
  localparam int unsigned NUM_OPERANDS = 2;
  localparam int unsigned FP32_WIDTH   = 32;
  localparam int unsigned FP16_WIDTH   = 16;
  localparam int unsigned NUM_LANES    = SLICE_WIDTH / FP16_WIDTH;  // Narrowest format sets it

  // Field layout of the two formats
  localparam int unsigned FP32_EXP_BITS = 8;
  localparam int unsigned FP32_MAN_BITS = 23;
  localparam int unsigned FP16_EXP_BITS = 5;
  localparam int unsigned FP16_MAN_BITS = 10;

  // Canonical quiet NaNs
  localparam logic [FP32_WIDTH-1:0] CANON_NAN_FP32 = 32'h7FC0_0000;
  localparam logic [FP16_WIDTH-1:0] CANON_NAN_FP16 = 16'h7E00;

  // ----------------------------------------------------------
  // Encodings
  // ----------------------------------------------------------
  typedef enum logic [0:0] {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic [2:0] {
    SGNJ  = 3'd0,
    SGNJN = 3'd1,
    SGNJX = 3'd2,
    FMIN  = 3'd3,
    FMAX  = 3'd4
  } operation_e;

  // IEEE exception flags, same order as the fflags CSR
  typedef struct packed {
    logic NV;  // Invalid
    logic DZ;  // Divide by zero
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  // One 16-bit chunk of the result plus the lane flags
  typedef struct packed {
    logic [FP16_WIDTH-1:0] result;
    status_t               status;
  } lane_word_t;

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------
  function automatic int unsigned fp_width(fp_format_e fmt);
    return (fmt == FP32) ? FP32_WIDTH : FP16_WIDTH;
  endfunction

  // Number of lanes a format fills in the slice word
  function automatic int unsigned lanes_of(fp_format_e fmt);
    return SLICE_WIDTH / fp_width(fmt);
  endfunction

endpackage
